// ==== verilog.f ====
+incdir+logic
logic/pong_geom_pkg.sv
logic/pong_play_pkg.sv
logic/paddle_ctrl.sv
logic/ball_engine.sv
logic/match_ctrl.sv
logic/pixel_mux.sv
logic/pong_core.sv
verif/pong_tb.sv

// ==== Makefile ====
# Verilator flow for the Pong playfield
VERILATOR ?= verilator
TOP       ?= pong_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --assert --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/pong_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pong_consts.svh"

module pong_tb;

    localparam int CLK_HALF_NS   = 2;
    localparam int RESET_CYCLES  = 40;     // Reset checks and paused key noise
    localparam int PADDLE_CYCLES = 240;
    localparam int BALL_CYCLES   = 400;
    localparam int POINT_BUDGET  = 600;    // One full rally with some slack
    localparam int SCORE_POINTS  = 3;
    localparam int PIXEL_SAMPLES = 300;
    localparam int AIM_OFFSET    = 16;     // Ball centre lands in the upper paddle zones
    localparam int TOTAL_CYCLES  = RESET_CYCLES + PADDLE_CYCLES + BALL_CYCLES +
                                   (`WIN_SCORE + 1) * POINT_BUDGET + PIXEL_SAMPLES;
    localparam int TIMEOUT_NS    = TOTAL_CYCLES * 2 * CLK_HALF_NS + 2000;

    logic                   BALL_CLOCK;
    logic                   reset;
    pong_play_pkg::keys_t   keys_1;
    pong_play_pkg::keys_t   keys_2;
    logic                   pause_toggle;
    logic                   restart;
    pong_geom_pkg::coord_t  x;
    pong_geom_pkg::coord_t  y;
    pong_geom_pkg::color_t  color;
    logic                   running;
    pong_play_pkg::score_t  score_1;
    pong_play_pkg::score_t  score_2;
    pong_play_pkg::winner_e winner;
    pong_geom_pkg::coord_t  ball_x;
    pong_geom_pkg::coord_t  ball_y;
    pong_geom_pkg::coord_t  paddle_1_y;
    pong_geom_pkg::coord_t  paddle_2_y;

    int unsigned rand_state = 82631;
    int          error_count = 0;
    int          test_errors = 0;     // error_count when the current test began
    int          test_number = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          exp_score_1 = 0;

    pong_core DUT (
        .BALL_CLOCK   (BALL_CLOCK),
        .reset        (reset),
        .keys_1       (keys_1),
        .keys_2       (keys_2),
        .pause_toggle (pause_toggle),
        .restart      (restart),
        .x            (x),
        .y            (y),
        .color        (color),
        .running      (running),
        .score_1      (score_1),
        .score_2      (score_2),
        .winner       (winner),
        .ball_x       (ball_x),
        .ball_y       (ball_y),
        .paddle_1_y   (paddle_1_y),
        .paddle_2_y   (paddle_2_y)
    );

    initial begin
        BALL_CLOCK = 1'b0;
        forever #CLK_HALF_NS BALL_CLOCK = ~BALL_CLOCK;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

    function automatic int unsigned next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state >> 8;   // Low bits of an LCG repeat quickly
    endfunction

    function automatic pong_play_pkg::keys_t random_key();
        int unsigned r;
        r = next_random();
        case (r % 4)
            0: return `KEY_UP;
            1: return `KEY_DOWN;
            2: return pong_play_pkg::keys_t'(r >> 4);   // Any code, mostly idle
            default: return '0;
        endcase
    endfunction

    // Paddle top after one running cycle with key k
    function automatic int step_paddle(input int p, input pong_play_pkg::keys_t k);
        if (k == `KEY_UP) begin
            return (p - `PADDLE_SPEED < 1) ? 1 : p - `PADDLE_SPEED;
        end else if (k == `KEY_DOWN) begin
            return (p + `PADDLE_SPEED > `FRAME_HEIGHT - `PADDLE_HEIGHT - 1) ?
                   `FRAME_HEIGHT - `PADDLE_HEIGHT - 1 : p + `PADDLE_SPEED;
        end
        return p;
    endfunction

    function automatic pong_geom_pkg::color_t expected_color(input int px, input int py);
        int bx;
        int by;
        int p1;
        int p2;
        bx = int'(ball_x);
        by = int'(ball_y);
        p1 = int'(paddle_1_y);
        p2 = int'(paddle_2_y);
        if (px >= bx && px <= bx + `BALL_SIZE && py >= by && py <= by + `BALL_SIZE) begin
            return `BALL_COLOR;
        end else if (px >= `PADDLE_1_X && px <= `PADDLE_1_X + `PADDLE_WIDTH &&
                     py >= p1 && py <= p1 + `PADDLE_HEIGHT) begin
            return `PADDLE_1_COLOR;
        end else if (px >= `PADDLE_2_X && px <= `PADDLE_2_X + `PADDLE_WIDTH &&
                     py >= p2 && py <= p2 + `PADDLE_HEIGHT) begin
            return `PADDLE_2_COLOR;
        end else if (px == 1 || py == 1 || px == `FRAME_WIDTH || py == `FRAME_HEIGHT) begin
            return `BORDER_COLOR;
        end
        return '0;
    endfunction

    task automatic next_cycle();
        @(posedge BALL_CLOCK);
        #1;   // Outputs settled, inputs change here
    endtask

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic pulse_pause();
        pause_toggle = 1'b1;
        next_cycle();
        pause_toggle = 1'b0;
    endtask

    task automatic pulse_restart();
        restart = 1'b1;
        next_cycle();
        restart = 1'b0;
    endtask

    task automatic finish_test(input string name);
        test_number++;
        if (error_count == test_errors) begin
            tests_passed++;
            $display("test %0d %s: pass", test_number, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail, %0d errors", test_number, name,
                     error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    task automatic check_reset_state();
        int i;
        assert (!running) else report_mismatch("running high after reset");
        assert (int'(score_1) == 0 && int'(score_2) == 0)
            else report_mismatch($sformatf("scores %0d:%0d after reset", score_1, score_2));
        assert (winner == pong_play_pkg::NONE)
            else report_mismatch($sformatf("winner %0d after reset", winner));
        for (i = 0; i < RESET_CYCLES - 2; i++) begin
            keys_1 = random_key();
            keys_2 = random_key();
            assert (int'(ball_x) == `INITIAL_BALL_X && int'(ball_y) == `INITIAL_BALL_Y)
                else report_mismatch($sformatf("ball at %0d,%0d while paused", ball_x, ball_y));
            assert (int'(paddle_1_y) == `INITIAL_PADDLE_Y &&
                    int'(paddle_2_y) == `INITIAL_PADDLE_Y)
                else report_mismatch($sformatf("paddles at %0d,%0d while paused",
                                               paddle_1_y, paddle_2_y));
            next_cycle();
        end
    endtask

    // Random key runs long enough to reach the clamps
    task automatic random_play(input int cycles, input bit check_paddles, input bit check_ball);
        int                   i;
        int                   hold;
        int                   exp_1;
        int                   exp_2;
        int                   prev_x;
        int                   dx;
        pong_play_pkg::keys_t run_1;
        pong_play_pkg::keys_t run_2;
        hold   = 0;
        exp_1  = `INITIAL_PADDLE_Y;
        exp_2  = `INITIAL_PADDLE_Y;
        prev_x = int'(ball_x);
        run_1  = '0;
        run_2  = '0;
        for (i = 0; i < cycles; i++) begin
            if (hold == 0) begin
                run_1 = random_key();
                run_2 = random_key();
                hold  = 20 + int'(next_random() % 40);
            end
            hold--;
            keys_1 = run_1;
            keys_2 = run_2;
            exp_1  = step_paddle(exp_1, run_1);
            exp_2  = step_paddle(exp_2, run_2);
            next_cycle();
            if (check_paddles) begin
                assert (int'(paddle_1_y) == exp_1)
                    else report_mismatch($sformatf("paddle_1_y %0d, expected %0d",
                                                   paddle_1_y, exp_1));
                assert (int'(paddle_2_y) == exp_2)
                    else report_mismatch($sformatf("paddle_2_y %0d, expected %0d",
                                                   paddle_2_y, exp_2));
            end
            if (check_ball) begin
                dx = int'(ball_x) - prev_x;
                // A serve jumps back to the centre column
                assert (int'(ball_x) == `INITIAL_BALL_X ||
                        (dx <= `SERVE_X_SPEED && dx >= -`SERVE_X_SPEED))
                    else report_mismatch($sformatf("ball_x jumped from %0d to %0d",
                                                   prev_x, ball_x));
                assert (int'(ball_x) < `FRAME_WIDTH &&
                        int'(ball_y) + `BALL_SIZE <= `FRAME_HEIGHT)
                    else report_mismatch($sformatf("ball at %0d,%0d outside the frame",
                                                   ball_x, ball_y));
            end
            prev_x = int'(ball_x);
        end
    endtask

    // Paddle 2 parked at the top, paddle 1 follows the ball
    task automatic track_and_score(input int points);
        int seen;
        int cycles;
        int target;
        seen   = 0;
        cycles = 0;
        while (seen < points && cycles < points * POINT_BUDGET && running) begin
            target = int'(ball_y) - AIM_OFFSET;
            if (target < 1) begin
                target = 1;
            end
            keys_2 = `KEY_UP;
            if (int'(paddle_1_y) > target + 2) begin
                keys_1 = `KEY_UP;
            end else if (int'(paddle_1_y) + 2 < target) begin
                keys_1 = `KEY_DOWN;
            end else begin
                keys_1 = '0;
            end
            next_cycle();
            cycles++;
            assert (int'(score_2) == 0)
                else report_mismatch($sformatf("score_2 changed to %0d", score_2));
            if (int'(score_1) != exp_score_1 || winner != pong_play_pkg::NONE || !running) begin
                seen++;
                if (exp_score_1 == `WIN_SCORE) begin
                    assert (int'(score_1) == 0 && int'(score_2) == 0 &&
                            winner == pong_play_pkg::PLAYER_1 && !running)
                        else report_mismatch($sformatf("win gave scores %0d:%0d winner %0d run %0b",
                                                       score_1, score_2, winner, running));
                end else begin
                    assert (int'(score_1) == exp_score_1 + 1 &&
                            winner == pong_play_pkg::NONE && running)
                        else report_mismatch($sformatf("score_1 %0d, expected %0d",
                                                       score_1, exp_score_1 + 1));
                end
                exp_score_1 = int'(score_1);   // Later points count from the score shown now
            end
        end
        if (seen < points) begin
            report_failure($sformatf("only %0d of %0d points were scored in %0d cycles",
                                     seen, points, cycles));
        end
    endtask

    task automatic pixel_check(input int samples);
        int                    i;
        int                    px;
        int                    py;
        int unsigned           r;
        pong_geom_pkg::color_t exp;
        for (i = 0; i < samples; i++) begin
            keys_1 = random_key();
            keys_2 = random_key();
            next_cycle();
            r = next_random();
            case (next_random() % 5)
                0: begin
                    px = int'(r % (`FRAME_WIDTH + 2));
                    py = int'((r >> 10) % (`FRAME_HEIGHT + 2));
                end
                1: begin
                    px = int'(ball_x) + int'(r % 16) - 3;
                    py = int'(ball_y) + int'((r >> 8) % 16) - 3;
                end
                2: begin
                    px = `PADDLE_1_X - 2 + int'(r % 15);
                    py = int'(paddle_1_y) - 3 + int'((r >> 8) % 77);
                end
                3: begin
                    px = `PADDLE_2_X - 2 + int'(r % 15);
                    py = int'(paddle_2_y) - 3 + int'((r >> 8) % 77);
                end
                default: begin
                    px = (r % 2 == 0) ? 1 : `FRAME_WIDTH;
                    py = int'((r >> 10) % (`FRAME_HEIGHT + 2));
                end
            endcase
            if (px < 0) begin
                px = 0;
            end
            if (py < 0) begin
                py = 0;
            end
            x = pong_geom_pkg::coord_t'(px);
            y = pong_geom_pkg::coord_t'(py);
            #1;
            exp = expected_color(px, py);
            assert (color == exp)
                else report_mismatch($sformatf("color %03b at %0d,%0d, expected %03b",
                                               color, px, py, exp));
        end
    endtask

    initial begin
        reset        = 1'b1;
        keys_1       = '0;
        keys_2       = '0;
        pause_toggle = 1'b0;
        restart      = 1'b0;
        x            = '0;
        y            = '0;
        repeat (2) @(posedge BALL_CLOCK);
        #1;
        reset = 1'b0;

        check_reset_state();
        finish_test("reset and paused hold");

        pulse_pause();
        random_play(PADDLE_CYCLES, 1'b1, 1'b0);
        finish_test("paddle motion");

        random_play(BALL_CYCLES, 1'b0, 1'b1);
        finish_test("ball motion");

        pulse_restart();
        pulse_pause();
        exp_score_1 = 0;
        track_and_score(SCORE_POINTS);
        finish_test("scoring");

        track_and_score(`WIN_SCORE + 1 - SCORE_POINTS);
        pulse_pause();
        assert (winner == pong_play_pkg::NONE && running)
            else report_mismatch($sformatf("after resume winner %0d run %0b", winner, running));
        finish_test("win");

        pixel_check(PIXEL_SAMPLES);
        finish_test("pixel colour");

        $display("tests run %0d, passed %0d, failed %0d", test_number, tests_passed,
                 tests_failed);
        if (tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/pong_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module pong_core (
    input  logic                   BALL_CLOCK,
    input  logic                   reset,
    input  pong_play_pkg::keys_t   keys_1,
    input  pong_play_pkg::keys_t   keys_2,
    input  logic                   pause_toggle,   // One-cycle pulse
    input  logic                   restart,        // One-cycle pulse
    input  pong_geom_pkg::coord_t  x,
    input  pong_geom_pkg::coord_t  y,
    output pong_geom_pkg::color_t  color,
    output logic                   running,
    output pong_play_pkg::score_t  score_1,
    output pong_play_pkg::score_t  score_2,
    output pong_play_pkg::winner_e winner,
    output pong_geom_pkg::coord_t  ball_x,
    output pong_geom_pkg::coord_t  ball_y,
    output pong_geom_pkg::coord_t  paddle_1_y,
    output pong_geom_pkg::coord_t  paddle_2_y
);

    logic point_1;   // Player 1 won the last rally
    logic point_2;

    paddle_ctrl paddle_1 (
        .BALL_CLOCK (BALL_CLOCK),
        .reset      (reset),
        .restart    (restart),
        .running    (running),
        .keys       (keys_1),
        .paddle_y   (paddle_1_y)
    );

    paddle_ctrl paddle_2 (
        .BALL_CLOCK (BALL_CLOCK),
        .reset      (reset),
        .restart    (restart),
        .running    (running),
        .keys       (keys_2),
        .paddle_y   (paddle_2_y)
    );

    ball_engine ball (
        .BALL_CLOCK (BALL_CLOCK),
        .reset      (reset),
        .restart    (restart),
        .running    (running),
        .paddle_1_y (paddle_1_y),
        .paddle_2_y (paddle_2_y),
        .ball_x     (ball_x),
        .ball_y     (ball_y),
        .point_1    (point_1),
        .point_2    (point_2)
    );

    match_ctrl match (
        .BALL_CLOCK   (BALL_CLOCK),
        .reset        (reset),
        .restart      (restart),
        .pause_toggle (pause_toggle),
        .point_1      (point_1),
        .point_2      (point_2),
        .running      (running),
        .score_1      (score_1),
        .score_2      (score_2),
        .winner       (winner)
    );

    pixel_mux pixel (
        .x          (x),
        .y          (y),
        .ball_x     (ball_x),
        .ball_y     (ball_y),
        .paddle_1_y (paddle_1_y),
        .paddle_2_y (paddle_2_y),
        .color      (color)
    );

endmodule

`default_nettype wire

// ==== logic/pixel_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pong_consts.svh"

module pixel_mux (
    input  pong_geom_pkg::coord_t x,
    input  pong_geom_pkg::coord_t y,
    input  pong_geom_pkg::coord_t ball_x,
    input  pong_geom_pkg::coord_t ball_y,
    input  pong_geom_pkg::coord_t paddle_1_y,
    input  pong_geom_pkg::coord_t paddle_2_y,
    output pong_geom_pkg::color_t color
);

    pong_geom_pkg::coord_t ball_x_end;     // Boxes include their far edge
    pong_geom_pkg::coord_t ball_y_end;
    pong_geom_pkg::coord_t paddle_1_y_end;
    pong_geom_pkg::coord_t paddle_2_y_end;

    logic in_ball;
    logic in_paddle_1;
    logic in_paddle_2;
    logic on_border;

    assign ball_x_end     = ball_x + pong_geom_pkg::coord_t'(`BALL_SIZE);
    assign ball_y_end     = ball_y + pong_geom_pkg::coord_t'(`BALL_SIZE);
    assign paddle_1_y_end = paddle_1_y + pong_geom_pkg::coord_t'(`PADDLE_HEIGHT);
    assign paddle_2_y_end = paddle_2_y + pong_geom_pkg::coord_t'(`PADDLE_HEIGHT);

    assign in_ball = (x >= ball_x) && (x <= ball_x_end) &&
                     (y >= ball_y) && (y <= ball_y_end);

    assign in_paddle_1 = (x >= `PADDLE_1_X) && (x <= `PADDLE_1_X + `PADDLE_WIDTH) &&
                         (y >= paddle_1_y) && (y <= paddle_1_y_end);
    assign in_paddle_2 = (x >= `PADDLE_2_X) && (x <= `PADDLE_2_X + `PADDLE_WIDTH) &&
                         (y >= paddle_2_y) && (y <= paddle_2_y_end);

    assign on_border = (x == 1) || (y == 1) || (x == `FRAME_WIDTH) || (y == `FRAME_HEIGHT);

    // Ball is drawn over the paddles, paddles over the border
    always_comb begin
        if (in_ball) begin
            color = `BALL_COLOR;
        end else if (in_paddle_1) begin
            color = `PADDLE_1_COLOR;
        end else if (in_paddle_2) begin
            color = `PADDLE_2_COLOR;
        end else if (on_border) begin
            color = `BORDER_COLOR;
        end else begin
            color = '0;   // Black background
        end
    end

endmodule

`default_nettype wire

// ==== logic/match_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pong_consts.svh"

module match_ctrl (
    input  logic                   BALL_CLOCK,
    input  logic                   reset,
    input  logic                   restart,
    input  logic                   pause_toggle,
    input  logic                   point_1,
    input  logic                   point_2,
    output logic                   running,
    output pong_play_pkg::score_t  score_1,
    output pong_play_pkg::score_t  score_2,
    output pong_play_pkg::winner_e winner
);

    pong_play_pkg::pause_state_e state;

    logic win_1;   // Player 1 scores while already at the top score
    logic win_2;

    assign win_1 = point_1 && (score_1 == pong_play_pkg::score_t'(`WIN_SCORE));
    assign win_2 = point_2 && (score_2 == pong_play_pkg::score_t'(`WIN_SCORE));

    assign running = (state == pong_play_pkg::RUNNING);

    always_ff @(posedge BALL_CLOCK) begin
        if (reset || restart) begin
            state   <= pong_play_pkg::PAUSED;
            score_1 <= '0;
            score_2 <= '0;
            winner  <= pong_play_pkg::NONE;
        end else if (win_1 || win_2) begin
            // Match over, back to 0:0 and wait for the players
            state   <= pong_play_pkg::PAUSED;
            score_1 <= '0;
            score_2 <= '0;
            winner  <= win_1 ? pong_play_pkg::PLAYER_1 : pong_play_pkg::PLAYER_2;
        end else begin
            if (point_1) begin
                score_1 <= score_1 + 1'b1;
            end
            if (point_2) begin
                score_2 <= score_2 + 1'b1;
            end
            if (pause_toggle) begin
                case (state)
                    pong_play_pkg::PAUSED: begin
                        state  <= pong_play_pkg::RUNNING;
                        winner <= pong_play_pkg::NONE;   // New match starts clean
                    end
                    default: state <= pong_play_pkg::PAUSED;
                endcase
            end
        end
    end

    // Scores only move on a point, a restart or a reset
    assert property (@(posedge BALL_CLOCK) disable iff (reset)
        ($changed(score_1) || $changed(score_2)) |->
            $past(point_1 || point_2 || restart || reset))
        else $error("score changed without a point");

endmodule

`default_nettype wire

// ==== logic/ball_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pong_consts.svh"

module ball_engine (
    input  logic                  BALL_CLOCK,
    input  logic                  reset,
    input  logic                  restart,
    input  logic                  running,
    input  pong_geom_pkg::coord_t paddle_1_y,
    input  pong_geom_pkg::coord_t paddle_2_y,
    output pong_geom_pkg::coord_t ball_x,
    output pong_geom_pkg::coord_t ball_y,
    output logic                  point_1,
    output logic                  point_2
);

    logic                  dir_left;    // 1 while heading for paddle 1
    logic                  dir_up;
    logic                  miss;        // Ball got past a paddle, waits for the edge
    pong_play_pkg::speed_t x_speed;
    pong_play_pkg::speed_t y_speed;

    pong_geom_pkg::coord_t x_step;
    pong_geom_pkg::coord_t y_step;
    pong_geom_pkg::coord_t ball_center;
    pong_geom_pkg::coord_t y_next;
    pong_geom_pkg::coord_t serve_y;
    logic                  in_col_1;
    logic                  in_col_2;
    logic                  hit_top;
    logic                  hit_bottom;
    logic                  at_edge;
    logic [2:0]            zone;        // 0 is a miss, 1 to 7 from top to bottom
    pong_play_pkg::speed_t zone_x_speed;
    pong_play_pkg::speed_t zone_y_speed;

    // Zone of the ball centre against one paddle
    function automatic logic [2:0] zone_of(input pong_geom_pkg::coord_t top,
                                           input pong_geom_pkg::coord_t center);
        pong_geom_pkg::coord_t rel;
        logic [2:0]            z;
        // Shifted by the corner zone so the upper corner starts at 0
        rel = center + pong_geom_pkg::coord_t'(`CORNER_HIT_ZONE) - top;
        if (rel < `CORNER_HIT_ZONE + `HIT_ZONE_1) begin
            z = 3'd1;
        end else if (rel < `CORNER_HIT_ZONE + `HIT_ZONE_2) begin
            z = 3'd2;
        end else if (rel < `CORNER_HIT_ZONE + `HIT_ZONE_3) begin
            z = 3'd3;
        end else if (rel < `CORNER_HIT_ZONE + `HIT_ZONE_4) begin
            z = 3'd4;
        end else if (rel < `CORNER_HIT_ZONE + `HIT_ZONE_5) begin
            z = 3'd5;
        end else if (rel < `CORNER_HIT_ZONE + `HIT_ZONE_MAX) begin
            z = 3'd6;
        end else if (rel < 2 * `CORNER_HIT_ZONE + `HIT_ZONE_MAX) begin
            z = 3'd7;
        end else begin
            z = 3'd0;
        end
        return z;
    endfunction

    assign x_step      = pong_geom_pkg::coord_t'(x_speed);
    assign y_step      = pong_geom_pkg::coord_t'(y_speed);
    assign ball_center = ball_y + pong_geom_pkg::coord_t'(`BALL_CENTER_OFFSET);

    // Contact columns, only checked when moving towards the paddle
    assign in_col_1 = dir_left && (ball_x >= `PADDLE_1_X + `PADDLE_WIDTH) &&
                      (ball_x <= `PADDLE_1_X + `PADDLE_WIDTH + x_step);
    assign in_col_2 = !dir_left && (ball_x + `BALL_SIZE + x_step >= `PADDLE_2_X) &&
                      (ball_x + `BALL_SIZE <= `PADDLE_2_X);

    assign zone = zone_of(in_col_1 ? paddle_1_y : paddle_2_y, ball_center);

    // Speeds 1/3, 2/2, 3/1, 4/0 from the corners in, mirrored below the middle
    assign zone_x_speed = (zone <= 3'd4) ? zone : 3'd0 - zone;
    assign zone_y_speed = 3'd4 - zone_x_speed;

    // Walls seen one step ahead
    assign hit_top    = dir_up && (ball_y <= y_step + `COLLISION_OFFSET);
    assign hit_bottom = !dir_up &&
                        (ball_y + y_step + `BALL_SIZE + `COLLISION_OFFSET >= `FRAME_HEIGHT);

    always_comb begin
        if (dir_up) begin
            y_next = (ball_y > y_step) ? ball_y - y_step : '0;
        end else if (ball_y + y_step > `FRAME_HEIGHT - `BALL_SIZE) begin
            y_next = pong_geom_pkg::coord_t'(`FRAME_HEIGHT - `BALL_SIZE);
        end else begin
            y_next = ball_y + y_step;
        end
    end

    assign at_edge = (ball_x <= `SERVE_X_SPEED + 1) || (ball_x + `BALL_SIZE >= `FRAME_WIDTH);

    // Serve level with the paddle on the side the ball left
    assign serve_y = ((ball_x < `HALF_FRAME_WIDTH) ? paddle_1_y : paddle_2_y) +
                     pong_geom_pkg::coord_t'(`HALF_PADDLE_HEIGHT - `BALL_CENTER_OFFSET);

    always_ff @(posedge BALL_CLOCK) begin
        if (reset || restart) begin
            ball_x   <= pong_geom_pkg::coord_t'(`INITIAL_BALL_X);
            ball_y   <= pong_geom_pkg::coord_t'(`INITIAL_BALL_Y);
            x_speed  <= pong_play_pkg::speed_t'(`SERVE_X_SPEED);
            y_speed  <= '0;
            dir_left <= 1'b0;
            dir_up   <= 1'b0;
            miss     <= 1'b0;
            point_1  <= 1'b0;
            point_2  <= 1'b0;
        end else begin
            point_1 <= 1'b0;
            point_2 <= 1'b0;
            if (running && miss && at_edge) begin
                ball_x  <= pong_geom_pkg::coord_t'(`INITIAL_BALL_X);
                ball_y  <= serve_y;
                x_speed <= pong_play_pkg::speed_t'(`SERVE_X_SPEED);
                y_speed <= '0;
                miss    <= 1'b0;
            end else if (running) begin
                ball_x <= dir_left ? ball_x - x_step : ball_x + x_step;
                ball_y <= y_next;   // Step with the old direction and speed
                if (hit_top) begin
                    dir_up <= 1'b0;
                end else if (hit_bottom) begin
                    dir_up <= 1'b1;
                end
                if (!miss && (in_col_1 || in_col_2)) begin
                    if (zone == 3'd0) begin
                        miss    <= 1'b1;
                        point_2 <= in_col_1;   // Paddle 1 missed
                        point_1 <= in_col_2;
                    end else begin
                        dir_left <= in_col_2;
                        x_speed  <= zone_x_speed;
                        y_speed  <= zone_y_speed;
                        if (zone < 3'd4) begin
                            dir_up <= 1'b1;
                        end else if (zone > 3'd4) begin
                            dir_up <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    assert property (@(posedge BALL_CLOCK) disable iff (reset) !(point_1 && point_2))
        else $error("both players scored in one cycle");

    assert property (@(posedge BALL_CLOCK) disable iff (reset) x_speed != '0)
        else $error("ball has no horizontal speed");

endmodule

`default_nettype wire

// ==== logic/paddle_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pong_consts.svh"

module paddle_ctrl (
    input  logic                  BALL_CLOCK,
    input  logic                  reset,
    input  logic                  restart,
    input  logic                  running,
    input  pong_play_pkg::keys_t  keys,
    output pong_geom_pkg::coord_t paddle_y
);

    pong_geom_pkg::coord_t y_up;     // One step up, held at the top row
    pong_geom_pkg::coord_t y_down;   // One step down, held above the bottom

    assign y_up = (paddle_y <= pong_geom_pkg::coord_t'(`PADDLE_SPEED)) ?
                  pong_geom_pkg::coord_t'(1) :
                  paddle_y - pong_geom_pkg::coord_t'(`PADDLE_SPEED);

    // Lowest allowed top edge is FRAME_HEIGHT - PADDLE_HEIGHT - 1
    assign y_down = (paddle_y + `PADDLE_SPEED >= `FRAME_HEIGHT - `PADDLE_HEIGHT - 1) ?
                    pong_geom_pkg::coord_t'(`FRAME_HEIGHT - `PADDLE_HEIGHT - 1) :
                    paddle_y + pong_geom_pkg::coord_t'(`PADDLE_SPEED);

    always_ff @(posedge BALL_CLOCK) begin
        if (reset || restart) begin
            paddle_y <= pong_geom_pkg::coord_t'(`INITIAL_PADDLE_Y);
        end else if (running) begin
            if (keys == `KEY_UP) begin
                paddle_y <= y_up;
            end else if (keys == `KEY_DOWN) begin
                paddle_y <= y_down;
            end
            // Any other code keeps the paddle where it is
        end
    end

    // Paddle never leaves the frame, whatever the key sequence
    assert property (@(posedge BALL_CLOCK) disable iff (reset)
        ##1 (paddle_y >= 1) && (paddle_y <= `FRAME_HEIGHT - `PADDLE_HEIGHT - 1))
        else $error("paddle_y %0d outside the frame", paddle_y);

endmodule

`default_nettype wire

// ==== logic/pong_play_pkg.sv ====
`default_nettype none

// Types that describe the state of a match
package pong_play_pkg;

    typedef logic [4:0] keys_t;     // Key code of one player pad
    typedef logic [2:0] score_t;    // Points, 0 to WIN_SCORE
    typedef logic [2:0] speed_t;    // Ball step per cycle on one axis

    // Last player to win a match
    typedef enum logic [1:0] {
        NONE,
        PLAYER_1,
        PLAYER_2
    } winner_e;

    typedef enum logic {
        PAUSED,
        RUNNING
    } pause_state_e;

endpackage

`default_nettype wire

// ==== logic/pong_geom_pkg.sv ====
`default_nettype none

// Types that describe positions and pixels on the playfield
package pong_geom_pkg;

    // One screen axis in pixels
    typedef logic [11:0] coord_t;

    // Red, green and blue, one bit each
    typedef logic [2:0] color_t;

endpackage

`default_nettype wire

// ==== logic/pong_consts.svh ====
`ifndef PONG_CONSTS_SVH
`define PONG_CONSTS_SVH

// Frame geometry in pixels
`define FRAME_WIDTH         640
`define FRAME_HEIGHT        480
`define HALF_FRAME_WIDTH    320

// Paddle placement and motion
`define PADDLE_1_X          20
`define PADDLE_2_X          610
`define PADDLE_WIDTH        10
`define PADDLE_HEIGHT       70
`define HALF_PADDLE_HEIGHT  35
`define PADDLE_SPEED        5      // Pixels per cycle
`define INITIAL_PADDLE_Y    205    // Paddle centred in the frame

// Ball
`define BALL_SIZE           10
`define BALL_CENTER_OFFSET  5
`define INITIAL_BALL_X      315
`define INITIAL_BALL_Y      235
`define SERVE_X_SPEED       4
`define COLLISION_OFFSET    3      // Wall contact margin

// Hit zones, measured from the paddle top
`define CORNER_HIT_ZONE     10     // Extends beyond each paddle end
`define HIT_ZONE_1          0
`define HIT_ZONE_2          14
`define HIT_ZONE_3          28
`define HIT_ZONE_4          42
`define HIT_ZONE_5          56
`define HIT_ZONE_MAX        70

`define WIN_SCORE           7

// Key codes from the player pads
`define KEY_UP              5'b00101
`define KEY_DOWN            5'b10001

// RGB colours
`define PADDLE_1_COLOR      3'b100
`define PADDLE_2_COLOR      3'b001
`define BALL_COLOR          3'b111
`define BORDER_COLOR        3'b010

`endif
